//--- Makefile
TOP = tb_rvc_expander

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f rvc_expander.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

//--- design/rvc_config.svh
/*
 * RVC expander constants
 * RV32 opcodes, funct3 codes and fixed encodings emitted by the decoders
 */
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// major opcodes of the expanded instructions
`define RVC_OPC_OP_IMM 7'b0010011
`define RVC_OPC_LOAD   7'b0000011
`define RVC_OPC_STORE  7'b0100011
`define RVC_OPC_LUI    7'b0110111
`define RVC_OPC_OP     7'b0110011

// funct3 fields
`define RVC_F3_ADD 3'b000
`define RVC_F3_SLL 3'b001
// word access, shared by lw and sw
`define RVC_F3_LW  3'b010
`define RVC_F3_XOR 3'b100
`define RVC_F3_SR  3'b101
`define RVC_F3_OR  3'b110
`define RVC_F3_AND 3'b111

// stack pointer is x2
`define RVC_REG_SP 5'd2

`define RVC_EBREAK 32'h0010_0073

`endif

//--- design/rvc_expander.sv
/*
 * RVC expander
 * picks the quadrant decoder result or passes a 32-bit word through,
 * and registers it at the fetch to decode boundary
 */
`timescale 1ns/1ps

module rvc_expander (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            valid_i,
    input  rvc_pkg::instr_t instr_i,
    output logic            valid_o,
    output rvc_pkg::instr_t instr_o,
    output logic            illegal_o
);

    rvc_pkg::cinstr_t     cinstr;
    rvc_pkg::decode_res_t q0_res;
    rvc_pkg::decode_res_t q1_res;
    rvc_pkg::decode_res_t q2_res;
    rvc_pkg::decode_res_t sel_res;
    rvc_pkg::decode_res_t res_q;
    logic                 valid_q;

    assign cinstr = instr_i[15:0];

    ////////////////////////////////////////
    // quadrant decoders
    ////////////////////////////////////////

    rvc_quadrant0_decoder u_q0 (
        .cinstr_i (cinstr),
        .result_o (q0_res)
    );

    rvc_quadrant1_decoder u_q1 (
        .cinstr_i (cinstr),
        .result_o (q1_res)
    );

    rvc_quadrant2_decoder u_q2 (
        .cinstr_i (cinstr),
        .result_o (q2_res)
    );

    // quadrant select, 11 marks an uncompressed word
    always_comb begin
        case (instr_i[1:0])
            2'b00:   sel_res = q0_res;
            2'b01:   sel_res = q1_res;
            2'b10:   sel_res = q2_res;
            default: sel_res = '{instr: instr_i, illegal: 1'b0};
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            res_q   <= '0;
        end else begin
            valid_q <= valid_i;
            // result holds while no word is fetched
            if (valid_i) begin
                res_q <= sel_res;
            end
        end
    end

    assign valid_o   = valid_q;
    assign instr_o   = res_q.instr;
    assign illegal_o = res_q.illegal;

endmodule

//--- design/rvc_pkg.sv
/*
 * RVC expander package
 * instruction and register types, decode result and compact register mapping
 */
package rvc_pkg;

    // full RV32 instruction word
    typedef logic [31:0] instr_t;

    // compressed half of the fetch word
    typedef logic [15:0] cinstr_t;

    // full register index x0..x31
    typedef logic [4:0] reg_addr_t;

    // compact register index, selects x8..x15
    typedef logic [2:0] creg_t;

    // one decoder result
    typedef struct packed {
        instr_t instr;
        logic   illegal;
    } decode_res_t;

    ////////////////////////////////////////
    // compact register expansion
    ////////////////////////////////////////

    // rd'/rs1'/rs2' map onto x8..x15
    function automatic reg_addr_t expand_creg(input creg_t creg);
        return {2'b01, creg};
    endfunction

endpackage

//--- design/rvc_quadrant0_decoder.sv
/*
 * RVC quadrant 0 decoder
 * expands c.addi4spn, c.lw and c.sw into RV32I form
 */
`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant0_decoder (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::decode_res_t result_o
);

    // compact registers of the CIW/CL/CS formats
    rvc_pkg::reg_addr_t rd_p;
    rvc_pkg::reg_addr_t rs1_p;

    assign rd_p  = rvc_pkg::expand_creg(cinstr_i[4:2]);
    assign rs1_p = rvc_pkg::expand_creg(cinstr_i[9:7]);

    always_comb begin
        result_o.instr   = '0;
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.addi4spn -> addi rd', sp, nzuimm
                result_o.instr = {
                    2'b00,
                    cinstr_i[10:7],
                    cinstr_i[12:11],
                    cinstr_i[5],
                    cinstr_i[6],
                    2'b00,
                    `RVC_REG_SP,
                    `RVC_F3_ADD,
                    rd_p,
                    `RVC_OPC_OP_IMM
                };
                // zero immediate is reserved
                if (cinstr_i[12:5] == 8'h00) begin
                    result_o.illegal = 1'b1;
                end
            end

            3'b010: begin
                // c.lw -> lw rd', offset(rs1')
                result_o.instr = {
                    5'b00000,
                    cinstr_i[5],
                    cinstr_i[12:10],
                    cinstr_i[6],
                    2'b00,
                    rs1_p,
                    `RVC_F3_LW,
                    rd_p,
                    `RVC_OPC_LOAD
                };
            end

            3'b110: begin
                // c.sw -> sw rs2', offset(rs1'), rs2' sits where rd' is for c.lw
                result_o.instr = {
                    5'b00000,
                    cinstr_i[5],
                    cinstr_i[12],
                    rd_p,
                    rs1_p,
                    `RVC_F3_LW,
                    cinstr_i[11:10],
                    cinstr_i[6],
                    2'b00,
                    `RVC_OPC_STORE
                };
            end

            default: begin
                result_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- design/rvc_quadrant1_decoder.sv
/*
 * RVC quadrant 1 decoder
 * expands the immediate and compact register arithmetic forms,
 * control transfer encodings are reported as illegal
 */
`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant1_decoder (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::decode_res_t result_o
);

    rvc_pkg::reg_addr_t rd;
    rvc_pkg::reg_addr_t rd_p;
    rvc_pkg::reg_addr_t rs2_p;
    // 6-bit signed immediate widened to an I-type field
    logic [11:0]        imm_sext;

    assign rd       = cinstr_i[11:7];
    assign rd_p     = rvc_pkg::expand_creg(cinstr_i[9:7]);
    assign rs2_p    = rvc_pkg::expand_creg(cinstr_i[4:2]);
    assign imm_sext = {{7{cinstr_i[12]}}, cinstr_i[6:2]};

    always_comb begin
        result_o.instr   = '0;
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.addi -> addi rd, rd, imm (c.nop when rd is x0)
                result_o.instr = {imm_sext, rd, `RVC_F3_ADD, rd, `RVC_OPC_OP_IMM};
            end

            3'b010: begin
                // c.li -> addi rd, x0, imm
                result_o.instr = {imm_sext, 5'd0, `RVC_F3_ADD, rd, `RVC_OPC_OP_IMM};
            end

            3'b011: begin
                if (rd == `RVC_REG_SP) begin
                    // c.addi16sp -> addi sp, sp, nzimm scaled by 16
                    result_o.instr = {
                        {3{cinstr_i[12]}},
                        cinstr_i[4:3],
                        cinstr_i[5],
                        cinstr_i[2],
                        cinstr_i[6],
                        4'b0000,
                        `RVC_REG_SP,
                        `RVC_F3_ADD,
                        `RVC_REG_SP,
                        `RVC_OPC_OP_IMM
                    };
                end else begin
                    // c.lui -> lui rd, nzimm
                    result_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, `RVC_OPC_LUI};
                end
                if ({cinstr_i[12], cinstr_i[6:2]} == 6'd0) begin
                    result_o.illegal = 1'b1;
                end
            end

            3'b100: begin
                case (cinstr_i[11:10])
                    2'b00, 2'b01: begin
                        // c.srli / c.srai, bit 10 picks the arithmetic shift
                        result_o.instr = {
                            1'b0,
                            cinstr_i[10],
                            5'b00000,
                            cinstr_i[6:2],
                            rd_p,
                            `RVC_F3_SR,
                            rd_p,
                            `RVC_OPC_OP_IMM
                        };
                        // shamt[5] set is not valid on RV32
                        if (cinstr_i[12]) begin
                            result_o.illegal = 1'b1;
                        end
                    end

                    2'b10: begin
                        // c.andi -> andi rd', rd', imm
                        result_o.instr = {imm_sext, rd_p, `RVC_F3_AND, rd_p, `RVC_OPC_OP_IMM};
                    end

                    default: begin
                        // register-register group on compact registers
                        case ({cinstr_i[12], cinstr_i[6:5]})
                            3'b000: begin
                                result_o.instr = {
                                    7'b0100000, rs2_p, rd_p, `RVC_F3_ADD, rd_p, `RVC_OPC_OP
                                };
                            end
                            3'b001: begin
                                result_o.instr = {
                                    7'b0000000, rs2_p, rd_p, `RVC_F3_XOR, rd_p, `RVC_OPC_OP
                                };
                            end
                            3'b010: begin
                                result_o.instr = {
                                    7'b0000000, rs2_p, rd_p, `RVC_F3_OR, rd_p, `RVC_OPC_OP
                                };
                            end
                            3'b011: begin
                                result_o.instr = {
                                    7'b0000000, rs2_p, rd_p, `RVC_F3_AND, rd_p, `RVC_OPC_OP
                                };
                            end
                            // c.subw, c.addw and reserved
                            default: begin
                                result_o.illegal = 1'b1;
                            end
                        endcase
                    end
                endcase
            end

            // c.jal, c.j, c.beqz, c.bnez are not supported
            default: begin
                result_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- design/rvc_quadrant2_decoder.sv
/*
 * RVC quadrant 2 decoder
 * expands c.slli, c.lwsp, c.swsp, c.mv, c.add and c.ebreak
 */
`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant2_decoder (
    input  rvc_pkg::cinstr_t     cinstr_i,
    output rvc_pkg::decode_res_t result_o
);

    // full register fields of the CR/CI/CSS formats
    rvc_pkg::reg_addr_t rd;
    rvc_pkg::reg_addr_t rs2;

    assign rd  = cinstr_i[11:7];
    assign rs2 = cinstr_i[6:2];

    always_comb begin
        result_o.instr   = '0;
        result_o.illegal = 1'b0;

        case (cinstr_i[15:13])
            3'b000: begin
                // c.slli -> slli rd, rd, shamt
                result_o.instr = {7'b0000000, rs2, rd, `RVC_F3_SLL, rd, `RVC_OPC_OP_IMM};
                if (cinstr_i[12]) begin
                    result_o.illegal = 1'b1;
                end
            end

            3'b010: begin
                // c.lwsp -> lw rd, offset(sp)
                result_o.instr = {
                    4'b0000,
                    cinstr_i[3:2],
                    cinstr_i[12],
                    cinstr_i[6:4],
                    2'b00,
                    `RVC_REG_SP,
                    `RVC_F3_LW,
                    rd,
                    `RVC_OPC_LOAD
                };
                if (rd == 5'd0) begin
                    result_o.illegal = 1'b1;
                end
            end

            3'b100: begin
                if (rs2 != 5'd0) begin
                    // c.mv -> add rd, x0, rs2 and c.add -> add rd, rd, rs2
                    result_o.instr = {
                        7'b0000000,
                        rs2,
                        cinstr_i[12] ? rd : 5'd0,
                        `RVC_F3_ADD,
                        rd,
                        `RVC_OPC_OP
                    };
                end else if (cinstr_i[12] && (rd == 5'd0)) begin
                    result_o.instr = `RVC_EBREAK;
                end else begin
                    // c.jr / c.jalr shapes
                    result_o.illegal = 1'b1;
                end
            end

            3'b110: begin
                // c.swsp -> sw rs2, offset(sp)
                result_o.instr = {
                    4'b0000,
                    cinstr_i[8:7],
                    cinstr_i[12],
                    rs2,
                    `RVC_REG_SP,
                    `RVC_F3_LW,
                    cinstr_i[11:9],
                    2'b00,
                    `RVC_OPC_STORE
                };
            end

            default: begin
                result_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- rvc_expander.f
+incdir+design
design/rvc_pkg.sv
design/rvc_quadrant0_decoder.sv
design/rvc_quadrant1_decoder.sv
design/rvc_quadrant2_decoder.sv
design/rvc_expander.sv
verif/tb_clock_gen.sv
verif/tb_rvc_expander.sv

//--- verif/tb_clock_gen.sv
/*
 * testbench clock and reset generator
 * 10 ns clock, reset held low for the first 16 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- verif/tb_rvc_expander.sv
/*
 * RVC expander testbench
 * directed expansion vectors per quadrant, pass-through and valid gating
 */
`timescale 1ns/1ps

`include "rvc_config.svh"

module tb_rvc_expander;

    // roughly 200 cycles of tests, ten times margin
    localparam int TEST_CYCLES    = 200;
    localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;
    localparam int DRIVE_DELAY    = 1;

    logic            clk;
    logic            rst_n;
    logic            valid_in;
    rvc_pkg::instr_t instr_in;
    logic            valid_out;
    rvc_pkg::instr_t instr_out;
    logic            illegal_out;

    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    int unsigned seed_val;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rvc_expander DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .valid_i   (valid_in),
        .instr_i   (instr_in),
        .valid_o   (valid_out),
        .instr_o   (instr_out),
        .illegal_o (illegal_out)
    );

    ////////////////////////////////////////
    // check helpers
    ////////////////////////////////////////

    task automatic compare(input string test_name, input string field,
                           input logic [31:0] exp_val, input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Fail %s: %s expected 0x%08h actual 0x%08h",
                     test_name, field, exp_val, act_val);
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_errors = 0;
    endtask

    task automatic finish_test(input string test_name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", test_name, test_errors);
        end
    endtask

    // presents one word for a cycle and checks the registered result
    task automatic expand_and_check(input string test_name, input rvc_pkg::instr_t word,
                                    input rvc_pkg::instr_t exp_instr, input logic exp_illegal);
        valid_in = 1'b1;
        instr_in = word;
        @(posedge clk);
        #DRIVE_DELAY;
        valid_in = 1'b0;
        compare(test_name, "valid_o", 32'd1, {31'd0, valid_out});
        compare(test_name, "illegal_o", {31'd0, exp_illegal}, {31'd0, illegal_out});
        // instr_o is undefined for illegal words
        if (!exp_illegal) begin
            compare(test_name, "instr_o", exp_instr, instr_out);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        start_test();
        compare("reset_state", "valid_o", 32'd0, {31'd0, valid_out});
        compare("reset_state", "illegal_o", 32'd0, {31'd0, illegal_out});
        compare("reset_state", "instr_o", 32'd0, instr_out);
        finish_test("reset_state");
    endtask

    task automatic test_pass_through();
        rvc_pkg::instr_t word;
        start_test();
        for (int i = 0; i < 8; i++) begin
            word = $urandom | 32'h3;
            expand_and_check("pass_through", word, word, 1'b0);
        end
        finish_test("pass_through");
    endtask

    task automatic test_quadrant0();
        start_test();
        expand_and_check("quadrant0", 32'h0000_0148, 32'h0841_0513, 1'b0);
        expand_and_check("quadrant0", 32'h0000_1fe4, 32'h3fc1_0493, 1'b0);
        expand_and_check("quadrant0", 32'h0000_4524, 32'h0485_2483, 1'b0);
        expand_and_check("quadrant0", 32'h0000_40c0, 32'h0044_a403, 1'b0);
        expand_and_check("quadrant0", 32'h0000_c52c, 32'h04b5_2423, 1'b0);
        // addi4spn with zero immediate, then funct3 001
        expand_and_check("quadrant0", 32'h0000_0004, 32'h0, 1'b1);
        expand_and_check("quadrant0", 32'h0000_2000, 32'h0, 1'b1);
        finish_test("quadrant0");
    endtask

    task automatic test_quadrant1();
        start_test();
        expand_and_check("quadrant1", 32'h0000_0001, 32'h0000_0013, 1'b0);
        expand_and_check("quadrant1", 32'h0000_157d, 32'hfff5_0513, 1'b0);
        expand_and_check("quadrant1", 32'h0000_429d, 32'h0070_0293, 1'b0);
        expand_and_check("quadrant1", 32'h0000_7781, 32'hfffe_07b7, 1'b0);
        expand_and_check("quadrant1", 32'h0000_7139, 32'hfc01_0113, 1'b0);
        expand_and_check("quadrant1", 32'h0000_800d, 32'h0034_5413, 1'b0);
        expand_and_check("quadrant1", 32'h0000_84fd, 32'h41f4_d493, 1'b0);
        expand_and_check("quadrant1", 32'h0000_9941, 32'hff05_7513, 1'b0);
        expand_and_check("quadrant1", 32'h0000_8c05, 32'h4094_0433, 1'b0);
        expand_and_check("quadrant1", 32'h0000_8d2d, 32'h00b5_4533, 1'b0);
        expand_and_check("quadrant1", 32'h0000_8e55, 32'h00d6_6633, 1'b0);
        expand_and_check("quadrant1", 32'h0000_8f7d, 32'h00f7_7733, 1'b0);
        // zero lui, shamt[5] set, subw shape
        expand_and_check("quadrant1", 32'h0000_6781, 32'h0, 1'b1);
        expand_and_check("quadrant1", 32'h0000_9001, 32'h0, 1'b1);
        expand_and_check("quadrant1", 32'h0000_9c05, 32'h0, 1'b1);
        finish_test("quadrant1");
    endtask

    task automatic test_quadrant2();
        start_test();
        expand_and_check("quadrant2", 32'h0000_0512, 32'h0045_1513, 1'b0);
        expand_and_check("quadrant2", 32'h0000_40b2, 32'h00c1_2083, 1'b0);
        expand_and_check("quadrant2", 32'h0000_5286, 32'h0601_2283, 1'b0);
        expand_and_check("quadrant2", 32'h0000_c606, 32'h0011_2623, 1'b0);
        expand_and_check("quadrant2", 32'h0000_c5a2, 32'h0c81_2423, 1'b0);
        expand_and_check("quadrant2", 32'h0000_852e, 32'h00b0_0533, 1'b0);
        expand_and_check("quadrant2", 32'h0000_952e, 32'h00b5_0533, 1'b0);
        expand_and_check("quadrant2", 32'h0000_9002, 32'h0010_0073, 1'b0);
        // lwsp into x0
        expand_and_check("quadrant2", 32'h0000_4032, 32'h0, 1'b1);
        finish_test("quadrant2");
    endtask

    task automatic test_dropped_forms();
        start_test();
        // c.j, c.jal, c.beqz, c.bnez, c.jr, c.jalr
        expand_and_check("dropped_forms", 32'h0000_a001, 32'h0, 1'b1);
        expand_and_check("dropped_forms", 32'h0000_2001, 32'h0, 1'b1);
        expand_and_check("dropped_forms", 32'h0000_c001, 32'h0, 1'b1);
        expand_and_check("dropped_forms", 32'h0000_e001, 32'h0, 1'b1);
        expand_and_check("dropped_forms", 32'h0000_8082, 32'h0, 1'b1);
        expand_and_check("dropped_forms", 32'h0000_9082, 32'h0, 1'b1);
        finish_test("dropped_forms");
    endtask

    task automatic test_valid_gating();
        start_test();
        // two words back to back, the second presented while the first is checked
        valid_in = 1'b1;
        instr_in = 32'h0000_157d;
        @(posedge clk);
        #DRIVE_DELAY;
        instr_in = 32'h0000_c52c;
        compare("valid_gating", "valid_o", 32'd1, {31'd0, valid_out});
        compare("valid_gating", "instr_o", 32'hfff5_0513, instr_out);
        @(posedge clk);
        #DRIVE_DELAY;
        valid_in = 1'b0;
        // an illegal word on the idle cycle must not reach the register
        instr_in = 32'h0000_0000;
        compare("valid_gating", "valid_o", 32'd1, {31'd0, valid_out});
        compare("valid_gating", "instr_o", 32'h04b5_2423, instr_out);
        // idle cycle keeps the last result
        @(posedge clk);
        #DRIVE_DELAY;
        compare("valid_gating", "valid_o", 32'd0, {31'd0, valid_out});
        compare("valid_gating", "instr_o", 32'h04b5_2423, instr_out);
        compare("valid_gating", "illegal_o", 32'd0, {31'd0, illegal_out});
        finish_test("valid_gating");
    endtask

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        valid_in     = 1'b0;
        instr_in     = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed_val     = $urandom(32'hdbb6);

        wait (rst_n === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;

        test_reset_state();
        test_pass_through();
        test_quadrant0();
        test_quadrant1();
        test_quadrant2();
        test_dropped_forms();
        test_valid_gating();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
